//--- compile.f
+incdir+.
udp_echo_pkg.sv
udp_port_filter.sv
udp_reply_header.sv
udp_payload_fifo.sv
udp_echo_core.sv
tb_clock_gen.sv
udp_echo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the udp echo testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module udp_echo_tb \
    -f compile.f \
    -o udp_echo_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/udp_echo_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict comes from the log only
if grep -q -x -F "*** PASSED ***" "$SIM_LOG"; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi

//--- udp_echo_tb.sv
// udp echo core testbench
`timescale 1ns/1ps

module udp_echo_tb;

    localparam int CLK_PERIOD = 40;
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    // 192.168.1.128
    localparam logic [31:0] LOCAL_IP = 32'hc0a8_0180;
    localparam logic [7:0] REPLY_TTL = 8'd64;
    localparam int MAX_BEATS = 6;
    localparam int STALL_BEATS = 24;
    // 17 random frames plus the long stalled one
    localparam int TOTAL_BEATS = 17 * MAX_BEATS + STALL_BEATS;
    localparam int DRAIN_LIMIT = 2000;
    localparam int READY_ON = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_OFF = 2;

    logic clk;
    logic rst;
    logic rx_hdr_valid;
    logic rx_hdr_ready;
    logic [31:0] rx_src_ip;
    logic [15:0] rx_src_port;
    logic [15:0] rx_dest_port;
    logic [15:0] rx_length;
    logic [63:0] rx_payload_data;
    logic [7:0] rx_payload_keep;
    logic rx_payload_valid;
    logic rx_payload_ready;
    logic rx_payload_last;
    logic rx_payload_user;
    logic tx_hdr_valid;
    logic tx_hdr_ready;
    logic [31:0] tx_src_ip;
    logic [31:0] tx_dest_ip;
    logic [15:0] tx_src_port;
    logic [15:0] tx_dest_port;
    logic [15:0] tx_length;
    logic [7:0] tx_ttl;
    logic [63:0] tx_payload_data;
    logic [7:0] tx_payload_keep;
    logic tx_payload_valid;
    logic tx_payload_ready;
    logic tx_payload_last;
    logic tx_payload_user;
    logic [7:0] led;

    // reference model, header entry {src_ip, dest_ip, src_port, dest_port, length, ttl}
    logic [119:0] hdr_q[$];
    // beat entry {user, last, keep, data}
    logic [73:0] beat_q[$];
    logic [73:0] popped;
    logic [31:0] exp_src_ip, exp_dest_ip;
    logic [15:0] exp_src_port, exp_dest_port, exp_length;
    logic [7:0] exp_ttl;
    logic [63:0] exp_data;
    logic [7:0] exp_keep;
    logic exp_last, exp_user;
    logic hdr_have = 1'b0;
    logic beat_have = 1'b0;
    logic hdr_taken = 1'b0;
    logic beat_taken = 1'b0;
    logic first_out = 1'b1;
    logic [7:0] frame_led = 8'd0;
    logic frame_sent = 1'b0;
    logic [31:0] ready_rnd;
    int hdr_mode = READY_ON;
    int pay_mode = READY_ON;
    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int hdrs_checked = 0;
    int beats_checked = 0;
    int stall_seen = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) i_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    udp_echo_core i_udp_echo_core (
        .clk (clk), .rst (rst),
        .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip (rx_src_ip), .rx_src_port (rx_src_port),
        .rx_dest_port (rx_dest_port), .rx_length (rx_length),
        .rx_payload_data (rx_payload_data), .rx_payload_keep (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid), .rx_payload_ready (rx_payload_ready),
        .rx_payload_last (rx_payload_last), .rx_payload_user (rx_payload_user),
        .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip (tx_src_ip), .tx_dest_ip (tx_dest_ip),
        .tx_src_port (tx_src_port), .tx_dest_port (tx_dest_port),
        .tx_length (tx_length), .tx_ttl (tx_ttl),
        .tx_payload_data (tx_payload_data), .tx_payload_keep (tx_payload_keep),
        .tx_payload_valid (tx_payload_valid), .tx_payload_ready (tx_payload_ready),
        .tx_payload_last (tx_payload_last), .tx_payload_user (tx_payload_user),
        .led (led)
    );

    task automatic mismatch_line(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        errors++;
        $display("MISMATCH time %0t ns: %s expected %0h actual %0h", $time, name,
                 expected, actual);
    endtask

    task automatic fail_with(input string what);
        errors++;
        $display("ERROR time %0t ns: %s", $time, what);
    endtask

    function automatic logic pick_ready(input int mode, input logic [1:0] r);
        if (mode == READY_ON) begin
            return 1'b1;
        end
        if (mode == READY_OFF) begin
            return 1'b0;
        end
        return r != 2'd0;
    endfunction

    // output ready patterns, driven on the falling edge
    initial begin
        tx_hdr_ready = 1'b0;
        tx_payload_ready = 1'b0;
        forever begin
            @(negedge clk);
            ready_rnd = $urandom();
            tx_hdr_ready = pick_ready(hdr_mode, ready_rnd[1:0]);
            tx_payload_ready = pick_ready(pay_mode, ready_rnd[3:2]);
        end
    end

    // note output transfers for the model update
    always @(posedge clk) begin
        hdr_taken <= !rst && tx_hdr_valid && tx_hdr_ready;
        beat_taken <= !rst && tx_payload_valid && tx_payload_ready;
    end

    // retire checked entries and expose the new heads
    always @(negedge clk) begin
        if (hdr_taken && hdr_q.size() > 0) begin
            void'(hdr_q.pop_front());
            hdrs_checked++;
        end
        if (beat_taken && beat_q.size() > 0) begin
            popped = beat_q.pop_front();
            if (first_out) begin
                frame_led = popped[7:0];
            end
            first_out = popped[72];
            beats_checked++;
        end
        hdr_have = hdr_q.size() > 0;
        if (hdr_have) begin
            {exp_src_ip, exp_dest_ip, exp_src_port, exp_dest_port, exp_length, exp_ttl} = hdr_q[0];
        end
        beat_have = beat_q.size() > 0;
        if (beat_have) begin
            {exp_user, exp_last, exp_keep, exp_data} = beat_q[0];
        end
    end

    wire hdr_xfer = tx_hdr_valid && tx_hdr_ready && hdr_have;
    wire beat_xfer = tx_payload_valid && tx_payload_ready && beat_have;

    // quiet outputs until the first request
    idle_check: assert property (@(posedge clk) disable iff (rst)
        !frame_sent |-> (!tx_hdr_valid && !tx_payload_valid && led == 8'd0))
        else fail_with("output became active before any frame was sent");
    hdr_pending_check: assert property (@(posedge clk) disable iff (rst)
        (tx_hdr_valid && tx_hdr_ready) |-> hdr_have)
        else fail_with("reply header sent with no echoed frame pending");
    beat_pending_check: assert property (@(posedge clk) disable iff (rst)
        (tx_payload_valid && tx_payload_ready) |-> beat_have)
        else fail_with("payload beat sent with no echoed beat pending");

    // header fields against the head of the header queue
    src_ip_check: assert property (@(posedge clk) disable iff (rst)
        hdr_xfer |-> tx_src_ip == exp_src_ip)
        else mismatch_line("tx_src_ip", 64'(exp_src_ip), 64'($sampled(tx_src_ip)));
    dest_ip_check: assert property (@(posedge clk) disable iff (rst)
        hdr_xfer |-> tx_dest_ip == exp_dest_ip)
        else mismatch_line("tx_dest_ip", 64'(exp_dest_ip), 64'($sampled(tx_dest_ip)));
    src_port_check: assert property (@(posedge clk) disable iff (rst)
        hdr_xfer |-> tx_src_port == exp_src_port)
        else mismatch_line("tx_src_port", 64'(exp_src_port), 64'($sampled(tx_src_port)));
    dest_port_check: assert property (@(posedge clk) disable iff (rst)
        hdr_xfer |-> tx_dest_port == exp_dest_port)
        else mismatch_line("tx_dest_port", 64'(exp_dest_port), 64'($sampled(tx_dest_port)));
    length_check: assert property (@(posedge clk) disable iff (rst)
        hdr_xfer |-> tx_length == exp_length)
        else mismatch_line("tx_length", 64'(exp_length), 64'($sampled(tx_length)));
    ttl_check: assert property (@(posedge clk) disable iff (rst)
        hdr_xfer |-> tx_ttl == exp_ttl)
        else mismatch_line("tx_ttl", 64'(exp_ttl), 64'($sampled(tx_ttl)));

    // payload beats against the head of the beat queue
    data_check: assert property (@(posedge clk) disable iff (rst)
        beat_xfer |-> tx_payload_data == exp_data)
        else mismatch_line("tx_payload_data", exp_data, $sampled(tx_payload_data));
    keep_check: assert property (@(posedge clk) disable iff (rst)
        beat_xfer |-> tx_payload_keep == exp_keep)
        else mismatch_line("tx_payload_keep", 64'(exp_keep), 64'($sampled(tx_payload_keep)));
    last_check: assert property (@(posedge clk) disable iff (rst)
        beat_xfer |-> tx_payload_last == exp_last)
        else mismatch_line("tx_payload_last", 64'(exp_last), 64'($sampled(tx_payload_last)));
    user_check: assert property (@(posedge clk) disable iff (rst)
        beat_xfer |-> tx_payload_user == exp_user)
        else mismatch_line("tx_payload_user", 64'(exp_user), 64'($sampled(tx_payload_user)));
    // led follows the first word once a frame has left
    led_check: assert property (@(posedge clk) disable iff (rst)
        (beat_xfer && tx_payload_last) |=> led == frame_led)
        else mismatch_line("led", 64'(frame_led), 64'($sampled(led)));

    task automatic drive_header(input bit echo, input logic [31:0] src_ip,
                                input logic [15:0] src_port, input logic [15:0] dest_port,
                                input logic [15:0] length);
        bit accepted;
        rx_src_ip = src_ip;
        rx_src_port = src_port;
        rx_dest_port = dest_port;
        rx_length = length;
        rx_hdr_valid = 1'b1;
        frame_sent = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            // ready is settled a quarter period after the falling edge
            #(CLK_PERIOD / 4);
            accepted = rx_hdr_ready;
            if (accepted && echo) begin
                // ports swapped, sender becomes destination
                hdr_q.push_back({LOCAL_IP, src_ip, dest_port, src_port, length, REPLY_TTL});
            end
            @(negedge clk);
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic offer_beat(input bit echo, input logic [63:0] data, input logic [7:0] keep,
                              input logic last, input logic user);
        bit accepted;
        rx_payload_data = data;
        rx_payload_keep = keep;
        rx_payload_last = last;
        rx_payload_user = user;
        rx_payload_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            #(CLK_PERIOD / 4);
            accepted = rx_payload_ready;
            if (!accepted && pay_mode == READY_OFF) begin
                stall_seen++;
            end
            if (accepted && echo) begin
                beat_q.push_back({user, last, keep, data});
            end
            @(negedge clk);
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic send_frame(input bit echo, input int nbeats);
        logic [31:0] src_ip;
        logic [31:0] rnd;
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [63:0] data;
        logic [7:0] keep;
        int nb_last;
        src_ip = $urandom();
        rnd = $urandom();
        src_port = rnd[15:0];
        dest_port = echo ? ECHO_PORT : rnd[31:16];
        if (!echo && dest_port == ECHO_PORT) begin
            dest_port = ECHO_PORT + 16'd1;
        end
        nb_last = $urandom_range(1, 8);
        // udp length counts the 8 header bytes
        length = 16'(8 + 8 * (nbeats - 1) + nb_last);
        drive_header(echo, src_ip, src_port, dest_port, length);
        for (int i = 0; i < nbeats; i++) begin
            data = {$urandom(), $urandom()};
            rnd = $urandom();
            keep = (i == nbeats - 1) ? (8'hff >> (8 - nb_last)) : 8'hff;
            offer_beat(echo, data, keep, i == nbeats - 1, rnd[0]);
        end
    endtask

    // mode changes land on the rising edge, ready driver reads them later
    task automatic set_ready_modes(input int h, input int p);
        @(posedge clk);
        hdr_mode = h;
        pay_mode = p;
        @(negedge clk);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((hdr_q.size() > 0 || beat_q.size() > 0) && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (hdr_q.size() > 0 || beat_q.size() > 0) begin
            fail_with("echoed frames did not leave the core in time");
        end
        // room for the led check after the last beat
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d failing checks", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // watchdog scaled by the beat count of all tests
    initial begin
        #(TOTAL_BEATS * 200 * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in %0d clock periods",
                 TOTAL_BEATS * 200);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rx_hdr_valid = 1'b0;
        rx_src_ip = '0;
        rx_src_port = '0;
        rx_dest_port = '0;
        rx_length = '0;
        rx_payload_data = '0;
        rx_payload_keep = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last = 1'b0;
        rx_payload_user = 1'b0;
        void'($urandom(32'h2569));
        wait (rst == 1'b0);
        @(negedge clk);

        repeat (20) @(negedge clk);
        end_test("quiet after reset");

        for (int k = 0; k < 3; k++) begin
            send_frame(1'b1, $urandom_range(1, MAX_BEATS));
        end
        wait_drained();
        end_test("basic echo");

        send_frame(1'b0, $urandom_range(1, MAX_BEATS));
        send_frame(1'b0, $urandom_range(1, MAX_BEATS));
        send_frame(1'b1, $urandom_range(1, MAX_BEATS));
        wait_drained();
        end_test("other ports dropped");

        // long frame against a stalled output fills the fifo
        stall_seen = 0;
        set_ready_modes(READY_OFF, READY_OFF);
        fork
            send_frame(1'b1, STALL_BEATS);
            begin
                repeat (60) @(posedge clk);
                hdr_mode = READY_RANDOM;
                pay_mode = READY_RANDOM;
            end
        join
        for (int k = 0; k < 3; k++) begin
            send_frame(1'b1, $urandom_range(1, MAX_BEATS));
        end
        wait_drained();
        stall_check: assert (stall_seen > 0)
            else fail_with("rx_payload_ready never dropped while the output was stalled");
        end_test("output back-pressure");

        for (int k = 0; k < 4; k++) begin
            send_frame(1'b1, $urandom_range(1, MAX_BEATS));
        end
        wait_drained();
        led_final_check: assert (led == frame_led)
            else mismatch_line("led", 64'(frame_led), 64'(led));
        end_test("led latch");

        // reply slot stays full while later headers queue up
        set_ready_modes(READY_OFF, READY_ON);
        fork
            for (int k = 0; k < 4; k++) begin
                send_frame(1'b1, $urandom_range(1, MAX_BEATS));
            end
            begin
                repeat (40) @(posedge clk);
                hdr_mode = READY_RANDOM;
            end
        join
        wait_drained();
        end_test("back-to-back frames");

        $display("tests %0d, headers checked %0d, beats checked %0d, failing checks %0d",
                 tests_run, hdrs_checked, beats_checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held for a fixed count, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- udp_echo_core.sv
// udp echo core top level
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_echo_core (
    input  logic                    clk,
    input  logic                    rst,

    // request header
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_src_ip,
    input  udp_echo_pkg::udp_port_t rx_src_port,
    input  udp_echo_pkg::udp_port_t rx_dest_port,
    input  udp_echo_pkg::udp_len_t  rx_length,

    // request payload
    input  udp_echo_pkg::payload_t  rx_payload_data,
    input  udp_echo_pkg::keep_t     rx_payload_keep,
    input  logic                    rx_payload_valid,
    output logic                    rx_payload_ready,
    input  logic                    rx_payload_last,
    input  logic                    rx_payload_user,

    // reply header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_src_ip,
    output udp_echo_pkg::ip_addr_t  tx_dest_ip,
    output udp_echo_pkg::udp_port_t tx_src_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,
    output logic [7:0]              tx_ttl,

    // reply payload
    output udp_echo_pkg::payload_t  tx_payload_data,
    output udp_echo_pkg::keep_t     tx_payload_keep,
    output logic                    tx_payload_valid,
    input  logic                    tx_payload_ready,
    output logic                    tx_payload_last,
    output logic                    tx_payload_user,

    output logic [7:0]              led
);

    logic reply_load;
    logic reply_busy;
    logic fifo_in_valid;
    logic fifo_in_ready;
    logic first_beat;

    // verdict per frame, gates the payload handshake only
    udp_port_filter i_udp_port_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_dest_port     (rx_dest_port),
        .reply_load       (reply_load),
        .reply_busy       (reply_busy),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .fifo_valid       (fifo_in_valid),
        .fifo_ready       (fifo_in_ready)
    );

    // header and payload leave independently
    udp_reply_header i_udp_reply_header (
        .clk           (clk),
        .rst           (rst),
        .load          (reply_load),
        .busy          (reply_busy),
        .req_src_ip    (rx_src_ip),
        .req_src_port  (rx_src_port),
        .req_dest_port (rx_dest_port),
        .req_length    (rx_length),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_src_ip     (tx_src_ip),
        .tx_dest_ip    (tx_dest_ip),
        .tx_src_port   (tx_src_port),
        .tx_dest_port  (tx_dest_port),
        .tx_length     (tx_length),
        .tx_ttl        (tx_ttl)
    );

    udp_payload_fifo #(
        .ADDR_W (`UDP_ECHO_FIFO_ADDR_W)
    ) i_udp_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (rx_payload_data),
        .in_keep   (rx_payload_keep),
        .in_last   (rx_payload_last),
        .in_user   (rx_payload_user),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (tx_payload_data),
        .out_keep  (tx_payload_keep),
        .out_last  (tx_payload_last),
        .out_user  (tx_payload_user),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    // led shows low byte of each echoed frame's first word
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'd0;
        end else if (tx_payload_valid && tx_payload_ready) begin
            if (first_beat) begin
                led <= tx_payload_data[7:0];
            end
            // next frame starts after last
            first_beat <= tx_payload_last;
        end
    end

endmodule

//--- udp_payload_fifo.sv
// payload fifo, first word fall through
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_payload_fifo #(
    parameter int ADDR_W = `UDP_ECHO_FIFO_ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst,

    // write side
    input  udp_echo_pkg::payload_t in_data,
    input  udp_echo_pkg::keep_t    in_keep,
    input  logic                   in_last,
    input  logic                   in_user,
    input  logic                   in_valid,
    output logic                   in_ready,

    // read side
    output udp_echo_pkg::payload_t out_data,
    output udp_echo_pkg::keep_t    out_keep,
    output logic                   out_last,
    output logic                   out_user,
    output logic                   out_valid,
    input  logic                   out_ready
);

    // user, last, keep and data packed into one entry
    localparam int WORD_W = `UDP_ECHO_DATA_W + `UDP_ECHO_KEEP_W + 2;

    logic [WORD_W-1:0] mem [0:(1 << ADDR_W)-1];

    // extra msb tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic out_free;
    logic in_xfer;
    logic bypass;
    logic pop;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign in_ready = !mem_full;
    assign in_xfer  = in_valid && in_ready;

    // output stage empty or drained this cycle
    assign out_free = !out_valid || out_ready;
    assign pop      = out_free && !mem_empty;
    // empty buffer, beat goes straight to the output stage
    assign bypass   = out_free && mem_empty && in_xfer;

    always_ff @(posedge clk) begin
        if (in_xfer && !bypass) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {in_user, in_last, in_keep, in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_xfer && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_free) begin
                out_valid <= pop || bypass;
            end
        end
    end

    // registered output, oldest entry first
    always_ff @(posedge clk) begin
        if (pop) begin
            {out_user, out_last, out_keep, out_data} <= mem[rd_ptr[ADDR_W-1:0]];
        end else if (bypass) begin
            {out_user, out_last, out_keep, out_data} <= {in_user, in_last, in_keep, in_data};
        end
    end

endmodule

//--- udp_reply_header.sv
// udp reply header holding register
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_reply_header (
    input  logic                    clk,
    input  logic                    rst,

    // load strobe from the filter
    input  logic                    load,
    output logic                    busy,

    // request fields
    input  udp_echo_pkg::ip_addr_t  req_src_ip,
    input  udp_echo_pkg::udp_port_t req_src_port,
    input  udp_echo_pkg::udp_port_t req_dest_port,
    input  udp_echo_pkg::udp_len_t  req_length,

    // reply header output
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_src_ip,
    output udp_echo_pkg::ip_addr_t  tx_dest_ip,
    output udp_echo_pkg::udp_port_t tx_src_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,
    output logic [7:0]              tx_ttl
);

    logic hdr_valid_reg;

    udp_echo_pkg::ip_addr_t  dest_ip_reg;
    udp_echo_pkg::udp_port_t src_port_reg;
    udp_echo_pkg::udp_port_t dest_port_reg;
    udp_echo_pkg::udp_len_t  length_reg;

    // slot valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_reg <= 1'b0;
        end else if (load) begin
            hdr_valid_reg <= 1'b1;
        end else if (tx_hdr_ready) begin
            // falls the cycle after the transfer
            hdr_valid_reg <= 1'b0;
        end
    end

    // reply fields, ports swapped and sender becomes destination
    always_ff @(posedge clk) begin
        if (load) begin
            dest_ip_reg   <= req_src_ip;
            src_port_reg  <= req_dest_port;
            dest_port_reg <= req_src_port;
            length_reg    <= req_length;
        end
    end

    assign busy         = hdr_valid_reg;
    assign tx_hdr_valid = hdr_valid_reg;

    assign tx_src_ip    = `UDP_ECHO_LOCAL_IP;
    assign tx_dest_ip   = dest_ip_reg;
    assign tx_src_port  = src_port_reg;
    assign tx_dest_port = dest_port_reg;
    // udp length carries over unchanged
    assign tx_length    = length_reg;
    assign tx_ttl       = `UDP_ECHO_TTL;

endmodule

//--- udp_port_filter.sv
// udp destination port filter
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_port_filter (
    input  logic                  clk,
    input  logic                  rst,

    // request header handshake
    input  logic                  rx_hdr_valid,
    output logic                  rx_hdr_ready,
    input  udp_echo_pkg::udp_port_t rx_dest_port,

    // reply header slot
    output logic                  reply_load,
    input  logic                  reply_busy,

    // request payload handshake
    input  logic                  rx_payload_valid,
    output logic                  rx_payload_ready,
    input  logic                  rx_payload_last,

    // fifo write handshake
    output logic                  fifo_valid,
    input  logic                  fifo_ready
);

    udp_echo_pkg::filter_state_e state;

    logic port_match;
    logic hdr_xfer;
    logic payload_xfer;

    // one compare per header
    assign port_match = (rx_dest_port == `UDP_ECHO_PORT);

    always_comb begin
        rx_hdr_ready     = 1'b0;
        reply_load       = 1'b0;
        rx_payload_ready = 1'b0;
        fifo_valid       = 1'b0;
        case (state)
            udp_echo_pkg::ST_IDLE: begin
                // stall a matching header until the reply slot frees up
                rx_hdr_ready = !(port_match && reply_busy);
                reply_load   = rx_hdr_valid && port_match && !reply_busy;
            end
            udp_echo_pkg::ST_FORWARD: begin
                // fifo back-pressure goes straight to the source
                rx_payload_ready = fifo_ready;
                fifo_valid       = rx_payload_valid;
            end
            udp_echo_pkg::ST_DISCARD: begin
                // drain, nothing reaches the fifo
                rx_payload_ready = 1'b1;
            end
            default: begin
                rx_hdr_ready = 1'b0;
            end
        endcase
    end

    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign payload_xfer = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_echo_pkg::ST_IDLE;
        end else begin
            case (state)
                udp_echo_pkg::ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? udp_echo_pkg::ST_FORWARD
                                            : udp_echo_pkg::ST_DISCARD;
                    end
                end
                udp_echo_pkg::ST_FORWARD,
                udp_echo_pkg::ST_DISCARD: begin
                    // frame ends on the beat taken with last
                    if (payload_xfer && rx_payload_last) begin
                        state <= udp_echo_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= udp_echo_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- udp_echo_pkg.sv
// udp echo shared types
`include "udp_echo_defines.svh"

package udp_echo_pkg;

    // per-frame verdict of the port filter
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_FORWARD = 2'd1,
        ST_DISCARD = 2'd2
    } filter_state_e;

    // ipv4 address
    typedef logic [31:0] ip_addr_t;

    // udp port number
    typedef logic [15:0] udp_port_t;

    // udp length field, header plus payload bytes
    typedef logic [15:0] udp_len_t;

    // one payload beat
    typedef logic [`UDP_ECHO_DATA_W-1:0] payload_t;

    // byte enables of one beat
    typedef logic [`UDP_ECHO_KEEP_W-1:0] keep_t;

endpackage

//--- udp_echo_defines.svh
// udp echo core constants
`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// destination port that gets echoed
`define UDP_ECHO_PORT 16'd1234

// local ipv4 address, 192.168.1.128
`define UDP_ECHO_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// ttl placed in every reply
`define UDP_ECHO_TTL 8'd64

// payload word and byte-enable widths
`define UDP_ECHO_DATA_W 64
`define UDP_ECHO_KEEP_W 8

// default payload fifo address width, 16 entries
`define UDP_ECHO_FIFO_ADDR_W 4

`endif
